// File: board_pkg.sv
//==========================================================================
// Board pin harness package.
// Pin vector widths, pin indices and the bus structs shared by the harness.
//==========================================================================
`default_nettype none

package board_pkg;

  // Pinmux vector widths, narrowed to the modelled pins.
  localparam int unsigned OutPinW   = 8;
  localparam int unsigned InPinW    = 6;
  localparam int unsigned InoutPinW = 16;

  // Default number of CHERI error classes.
  localparam int unsigned CheriErrWidth = 9;
  // Default number of modelled I2C buses.
  localparam int unsigned NumI2cBuses = 3;

  typedef logic [OutPinW-1:0]       out_pins_t;
  typedef logic [InPinW-1:0]        in_pins_t;
  typedef logic [InoutPinW-1:0]     inout_pins_t;
  typedef logic [CheriErrWidth-1:0] cheri_err_t;

  // Output-only pins.
  localparam int unsigned OUT_PIN_SER0_TX  = 0;
  localparam int unsigned OUT_PIN_RS485_TX = 1;
  localparam int unsigned OUT_PIN_MB4      = 2;
  localparam int unsigned OUT_PIN_MB7      = 3;
  localparam int unsigned OUT_PIN_MB10     = 4;

  // Input-only pins.
  localparam int unsigned IN_PIN_SER0_RX  = 0;
  localparam int unsigned IN_PIN_RS485_RX = 1;
  localparam int unsigned IN_PIN_MB3      = 2;
  localparam int unsigned IN_PIN_MB8      = 3;

  // Bidirectional pins carrying I2C.
  localparam int unsigned INOUT_PIN_SCL1       = 0;
  localparam int unsigned INOUT_PIN_SDA1       = 1;
  localparam int unsigned INOUT_PIN_RPH_G0     = 2;
  localparam int unsigned INOUT_PIN_RPH_G1     = 3;
  localparam int unsigned INOUT_PIN_RPH_G2_SDA = 4;
  localparam int unsigned INOUT_PIN_RPH_G3_SCL = 5;

  // PMOD1 flash pins in the order CS, COPI, CIPO, SCK.
  localparam int unsigned INOUT_PIN_PMOD1_1 = 6;
  localparam int unsigned INOUT_PIN_PMOD1_2 = 7;
  localparam int unsigned INOUT_PIN_PMOD1_3 = 8;
  localparam int unsigned INOUT_PIN_PMOD1_4 = 9;

  // Loopback pins.
  localparam int unsigned INOUT_PIN_PMOD0_8   = 10;
  localparam int unsigned INOUT_PIN_PMOD0_10  = 11;
  localparam int unsigned INOUT_PIN_PMOD0_1   = 12;
  localparam int unsigned INOUT_PIN_AH_TMPIO0 = 13;
  localparam int unsigned INOUT_PIN_AH_TMPIO1 = 14;
  // Arduino IO8 and IO9 share the last pad, so that loop reads back its own pin.
  localparam int unsigned INOUT_PIN_AH_TMPIO8 = 15;
  localparam int unsigned INOUT_PIN_AH_TMPIO9 = 15;

  // Per-bus pin tables.
  // Bus 0 is QWIIC1, bus 1 the HAT ID EEPROM, bus 2 the HAT secondary bus.
  localparam int unsigned I2cSclIdx [NumI2cBuses] = '{
    INOUT_PIN_SCL1, INOUT_PIN_RPH_G1, INOUT_PIN_RPH_G3_SCL
  };
  localparam int unsigned I2cSdaIdx [NumI2cBuses] = '{
    INOUT_PIN_SDA1, INOUT_PIN_RPH_G0, INOUT_PIN_RPH_G2_SDA
  };

  // One I2C bus as seen by one side.
  typedef struct packed {
    logic scl;
    logic sda;
  } i2c_bus_t;

  // SPI lines driven towards the flash.
  typedef struct packed {
    logic sck;
    logic cs;
    logic copi;
  } spi_ctrl_t;

  // RS-485 transceiver control from the system.
  typedef struct packed {
    logic tx;
    logic tx_enable;
    logic rx_enable;
  } rs485_ctrl_t;

endpackage

`default_nettype wire

// File: pin_drive.sv
//==========================================================================
// Pin drive.
// Turns controller pin levels and enables into bus drive levels.
// A released open-drain or tristate pin reads as 1.
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module pin_drive import board_pkg::*; #(
  parameter int unsigned NumI2cBuses = board_pkg::NumI2cBuses
) (
  // System pinmux side.
  input  out_pins_t                   sys_out_pins_i,
  input  inout_pins_t                 sys_inout_to_i,
  input  inout_pins_t                 sys_inout_en_i,
  input  rs485_ctrl_t                 rs485_i,
  // Controller levels after release.
  output i2c_bus_t [NumI2cBuses-1:0]  i2c_ctrl_o,
  output spi_ctrl_t                   spi_o,
  output logic                        uart_tx_o,
  output logic                        rs485_line_o
);

  // Drive level of every bidirectional pin.
  inout_pins_t drive_lvl;

  // A low enable releases the pin.
  // The board pull-up then holds it at 1.
  assign drive_lvl = sys_inout_to_i | ~sys_inout_en_i;

  // Pick the clock and data pins of each I2C bus.
  for (genvar b = 0; b < NumI2cBuses; b++) begin : g_i2c
    assign i2c_ctrl_o[b].scl = drive_lvl[I2cSclIdx[b]];
    assign i2c_ctrl_o[b].sda = drive_lvl[I2cSdaIdx[b]];
  end

  // PMOD1 flash lines.
  // CS idles high when released, which deselects the flash.
  assign spi_o.cs   = drive_lvl[INOUT_PIN_PMOD1_1];
  assign spi_o.copi = drive_lvl[INOUT_PIN_PMOD1_2];
  assign spi_o.sck  = drive_lvl[INOUT_PIN_PMOD1_4];

  // System UART goes straight out.
  assign uart_tx_o = sys_out_pins_i[OUT_PIN_SER0_TX];

  // RS-485 driver.
  // With the driver disabled the line idles at the UART stop level.
  assign rs485_line_o = rs485_i.tx_enable ? rs485_i.tx : 1'b1;

endmodule

`default_nettype wire

// File: bus_resolve.sv
//==========================================================================
// Bus resolution.
// Wired-ANDs the I2C buses, gates the RS-485 receiver, re-times the
// loopbacks and builds the pin vectors returned to the system.
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module bus_resolve import board_pkg::*; #(
  parameter int unsigned NumI2cBuses = board_pkg::NumI2cBuses
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // I2C levels from both ends of each bus.
  input  i2c_bus_t [NumI2cBuses-1:0]  i2c_ctrl_i,
  input  i2c_bus_t [NumI2cBuses-1:0]  i2c_dev_i,
  // Loopback sources.
  input  out_pins_t                   sys_out_pins_i,
  input  inout_pins_t                 sys_inout_to_i,
  // Device returns.
  input  logic                        rs485_rx_enable_i,
  input  logic                        rs485_dev_tx_i,
  input  logic                        spi_cipo_i,
  input  logic                        uart_rx_i,
  // Resolved buses and vectors back to the system.
  output i2c_bus_t [NumI2cBuses-1:0]  i2c_bus_o,
  output in_pins_t                    sys_in_pins_o,
  output inout_pins_t                 sys_inout_from_o
);

  localparam int unsigned LoopbackW = 6;

  i2c_bus_t [NumI2cBuses-1:0] i2c_res;
  logic [LoopbackW-1:0]       loopback_d;
  logic [LoopbackW-1:0]       loopback_q;
  logic                       rs485_rx;

  // Open-drain bus. Either side pulling low wins.
  // The controller must see the same level or it reports contention.
  assign i2c_res   = i2c_ctrl_i & i2c_dev_i;
  assign i2c_bus_o = i2c_res;

  // Receiver disabled reads as idle.
  assign rs485_rx = rs485_rx_enable_i ? rs485_dev_tx_i : 1'b1;

  // Loopback sources, one bit per path.
  assign loopback_d = {
    sys_inout_to_i[INOUT_PIN_AH_TMPIO8],  // Arduino IO8 -> IO9.
    sys_inout_to_i[INOUT_PIN_AH_TMPIO1],  // Arduino IO1 -> IO0.
    sys_out_pins_i[OUT_PIN_MB10],         // mikroBUS PWM -> PMOD0.1.
    sys_out_pins_i[OUT_PIN_MB7],          // mikroBUS UART TX -> RX.
    sys_out_pins_i[OUT_PIN_MB4],          // mikroBUS SPI COPI -> CIPO.
    sys_inout_to_i[INOUT_PIN_PMOD0_8]     // PMOD0.8 -> PMOD0.10.
  };

  // One register stage breaks the net-level loop from the pinmux
  // outputs back to its inputs.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      loopback_q <= '0;
    end else begin
      loopback_q <= loopback_d;
    end
  end

  // Input-only vector.
  always_comb begin
    // Unmodelled inputs sit at their pulled-up level.
    sys_in_pins_o                  = '1;
    sys_in_pins_o[IN_PIN_SER0_RX]  = uart_rx_i;
    sys_in_pins_o[IN_PIN_RS485_RX] = rs485_rx;
    sys_in_pins_o[IN_PIN_MB3]      = loopback_q[1];
    sys_in_pins_o[IN_PIN_MB8]      = loopback_q[2];
  end

  // Bidirectional vector.
  always_comb begin
    // Pins with no model on the board read high.
    sys_inout_from_o = '1;
    // Each controller reads back the resolved bus.
    for (int b = 0; b < NumI2cBuses; b++) begin
      sys_inout_from_o[I2cSclIdx[b]] = i2c_res[b].scl;
      sys_inout_from_o[I2cSdaIdx[b]] = i2c_res[b].sda;
    end
    // Flash data out.
    sys_inout_from_o[INOUT_PIN_PMOD1_3]   = spi_cipo_i;
    // Loopback destinations.
    sys_inout_from_o[INOUT_PIN_PMOD0_10]  = loopback_q[0];
    sys_inout_from_o[INOUT_PIN_PMOD0_1]   = loopback_q[3];
    sys_inout_from_o[INOUT_PIN_AH_TMPIO0] = loopback_q[4];
    sys_inout_from_o[INOUT_PIN_AH_TMPIO9] = loopback_q[5];
  end

endmodule

`default_nettype wire

// File: cheri_err_monitor.sv
//==========================================================================
// CHERI error monitor.
// Keeps a sticky mask of the error classes seen and pulses once per class
// on its first occurrence.
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module cheri_err_monitor #(
  parameter int unsigned CheriErrWidth = board_pkg::CheriErrWidth
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Error flags from the core, modulated for LEDs.
  input  logic [CheriErrWidth-1:0] cheri_err_i,
  // Classes seen since reset.
  output logic [CheriErrWidth-1:0] cheri_seen_o,
  // One-cycle pulse on a first occurrence.
  output logic [CheriErrWidth-1:0] cheri_new_o
);

  logic [CheriErrWidth-1:0] seen_q;
  logic [CheriErrWidth-1:0] new_q;
  logic [CheriErrWidth-1:0] first_hit;

  // Raised bits not yet in the mask.
  // The flags blink, so a class is only new the first time round.
  assign first_hit = cheri_err_i & ~seen_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seen_q <= '0;
      new_q  <= '0;
    end else begin
      // The mask only ever gains bits.
      seen_q <= seen_q | cheri_err_i;
      // Pulse lasts one cycle, as the mask closes the bit behind it.
      new_q  <= first_hit;
    end
  end

  assign cheri_seen_o = seen_q;
  assign cheri_new_o  = new_q;

endmodule

`default_nettype wire

// File: board_harness.sv
//==========================================================================
// Board pin harness top level.
// Connects the system pinmux vectors to the off-chip device buses.
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module board_harness import board_pkg::*; #(
  parameter int unsigned NumI2cBuses   = board_pkg::NumI2cBuses,
  parameter int unsigned CheriErrWidth = $bits(cheri_err_t)
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // System pinmux side.
  input  out_pins_t                   sys_out_pins_i,
  input  inout_pins_t                 sys_inout_to_i,
  input  inout_pins_t                 sys_inout_en_i,
  input  rs485_ctrl_t                 rs485_i,
  input  cheri_err_t                  cheri_err_i,
  output in_pins_t                    sys_in_pins_o,
  output inout_pins_t                 sys_inout_from_o,
  // I2C devices.
  output i2c_bus_t [NumI2cBuses-1:0]  i2c_bus_o,
  input  i2c_bus_t [NumI2cBuses-1:0]  i2c_dev_i,
  // PMOD1 flash.
  output spi_ctrl_t                   spi_o,
  input  logic                        spi_cipo_i,
  // UART.
  output logic                        uart_tx_o,
  input  logic                        uart_rx_i,
  // RS-485 transceiver.
  output logic                        rs485_dev_rx_o,
  input  logic                        rs485_dev_tx_i,
  // CHERI error reporting.
  output cheri_err_t                  cheri_seen_o,
  output cheri_err_t                  cheri_new_o
);

  // Controller levels after release.
  i2c_bus_t [NumI2cBuses-1:0] i2c_ctrl;

  // Release defaults for all driven pins.
  pin_drive #(
    .NumI2cBuses (NumI2cBuses)
  ) u_pin_drive (
    .sys_out_pins_i (sys_out_pins_i),
    .sys_inout_to_i (sys_inout_to_i),
    .sys_inout_en_i (sys_inout_en_i),
    .rs485_i        (rs485_i),
    .i2c_ctrl_o     (i2c_ctrl),
    .spi_o          (spi_o),
    .uart_tx_o      (uart_tx_o),
    .rs485_line_o   (rs485_dev_rx_o)
  );

  // Bus resolution and the return path to the system.
  bus_resolve #(
    .NumI2cBuses (NumI2cBuses)
  ) u_bus_resolve (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .i2c_ctrl_i        (i2c_ctrl),
    .i2c_dev_i         (i2c_dev_i),
    .sys_out_pins_i    (sys_out_pins_i),
    .sys_inout_to_i    (sys_inout_to_i),
    .rs485_rx_enable_i (rs485_i.rx_enable),
    .rs485_dev_tx_i    (rs485_dev_tx_i),
    .spi_cipo_i        (spi_cipo_i),
    .uart_rx_i         (uart_rx_i),
    .i2c_bus_o         (i2c_bus_o),
    .sys_in_pins_o     (sys_in_pins_o),
    .sys_inout_from_o  (sys_inout_from_o)
  );

  // First-occurrence tracking of CHERI errors.
  cheri_err_monitor #(
    .CheriErrWidth (CheriErrWidth)
  ) u_cheri_err_monitor (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cheri_err_i  (cheri_err_i),
    .cheri_seen_o (cheri_seen_o),
    .cheri_new_o  (cheri_new_o)
  );

endmodule

`default_nettype wire

// File: board_harness_assert.sv
//==========================================================================
// Board harness assertions.
// Sticky CHERI mask rules and the one-cycle loopback delay.
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module board_harness_assert import board_pkg::*; #(
  parameter int unsigned CheriErrWidth = board_pkg::CheriErrWidth
) (
  input logic                     clk_i,
  input logic                     rst_ni,
  input out_pins_t                sys_out_pins_i,
  input inout_pins_t              sys_inout_to_i,
  input in_pins_t                 sys_in_pins_o,
  input inout_pins_t              sys_inout_from_o,
  input logic [CheriErrWidth-1:0] cheri_seen_o,
  input logic [CheriErrWidth-1:0] cheri_new_o
);

  // Number of failed assertions.
  int fail_cnt = 0;

  // A pulse only for a class that was not yet in the mask.
  new_only_unseen: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cheri_new_o & $past(cheri_seen_o)) == '0)
    else begin
      $error("cheri_new_o pulsed for a class already seen");
      fail_cnt++;
    end

  // The mask keeps every bit it has gained.
  mask_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cheri_seen_o & $past(cheri_seen_o)) == $past(cheri_seen_o))
    else begin
      $error("cheri_seen_o lost a bit");
      fail_cnt++;
    end

  // Each loopback lands one clock after its source.
  loopback_delay: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sys_inout_from_o[INOUT_PIN_PMOD0_10] == $past(sys_inout_to_i[INOUT_PIN_PMOD0_8]) &&
    sys_in_pins_o[IN_PIN_MB3] == $past(sys_out_pins_i[OUT_PIN_MB4]) &&
    sys_in_pins_o[IN_PIN_MB8] == $past(sys_out_pins_i[OUT_PIN_MB7]) &&
    sys_inout_from_o[INOUT_PIN_PMOD0_1] == $past(sys_out_pins_i[OUT_PIN_MB10]) &&
    sys_inout_from_o[INOUT_PIN_AH_TMPIO0] == $past(sys_inout_to_i[INOUT_PIN_AH_TMPIO1]) &&
    sys_inout_from_o[INOUT_PIN_AH_TMPIO9] == $past(sys_inout_to_i[INOUT_PIN_AH_TMPIO8]))
    else begin
      $error("loopback output differs from its source one cycle earlier");
      fail_cnt++;
    end

endmodule

bind board_harness board_harness_assert #(
  .CheriErrWidth (CheriErrWidth)
) u_board_harness_assert (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .sys_out_pins_i   (sys_out_pins_i),
  .sys_inout_to_i   (sys_inout_to_i),
  .sys_in_pins_o    (sys_in_pins_o),
  .sys_inout_from_o (sys_inout_from_o),
  .cheri_seen_o     (cheri_seen_o),
  .cheri_new_o      (cheri_new_o)
);

`default_nettype wire

// File: tb_board_harness.sv
//==========================================================================
// Board pin harness testbench.
// Applies a table of pin stimulus and checks every output against a model
// of the harness pin rules, one row per clock.
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module tb_board_harness import board_pkg::*; ();

  localparam int Period     = 20;
  localparam int DriveDelay = 2;
  localparam int NumRows    = 32;
  localparam int Watchdog   = (NumRows + 12) * Period;

  // Clock and data pins of each I2C bus, per the board wiring.
  localparam int unsigned SclPin [NumI2cBuses] = '{
    INOUT_PIN_SCL1, INOUT_PIN_RPH_G1, INOUT_PIN_RPH_G3_SCL
  };
  localparam int unsigned SdaPin [NumI2cBuses] = '{
    INOUT_PIN_SDA1, INOUT_PIN_RPH_G0, INOUT_PIN_RPH_G2_SDA
  };

  // One row of stimulus.
  typedef struct packed {
    out_pins_t                  out_pins;
    inout_pins_t                inout_to;
    inout_pins_t                inout_en;
    rs485_ctrl_t                rs485;
    cheri_err_t                 cheri;
    i2c_bus_t [NumI2cBuses-1:0] i2c_dev;
    logic                       cipo;
    logic                       uart_rx;
    logic                       dev_tx;
  } stim_t;

  // Expected outputs for one row.
  typedef struct packed {
    in_pins_t                   in_pins;
    inout_pins_t                inout_from;
    i2c_bus_t [NumI2cBuses-1:0] i2c_bus;
    spi_ctrl_t                  spi;
    logic                       uart_tx;
    logic                       rs485_rx;
    cheri_err_t                 seen;
    cheri_err_t                 pulse;
  } expect_t;

  logic                       clk_i = 1'b0;
  logic                       rst_ni;
  out_pins_t                  sys_out_pins_i;
  inout_pins_t                sys_inout_to_i;
  inout_pins_t                sys_inout_en_i;
  rs485_ctrl_t                rs485_i;
  cheri_err_t                 cheri_err_i;
  in_pins_t                   sys_in_pins_o;
  inout_pins_t                sys_inout_from_o;
  i2c_bus_t [NumI2cBuses-1:0] i2c_bus_o;
  i2c_bus_t [NumI2cBuses-1:0] i2c_dev_i;
  spi_ctrl_t                  spi_o;
  logic                       spi_cipo_i;
  logic                       uart_tx_o;
  logic                       uart_rx_i;
  logic                       rs485_dev_rx_o;
  logic                       rs485_dev_tx_i;
  cheri_err_t                 cheri_seen_o;
  cheri_err_t                 cheri_new_o;

  stim_t   stim_tbl [NumRows];
  expect_t exp_tbl  [NumRows];
  integer  seed = 32'h535;
  int      checks = 0;
  int      errors = 0;
  int      assert_fails;

  board_harness #(
    .NumI2cBuses   (NumI2cBuses),
    .CheriErrWidth (CheriErrWidth)
  ) board_harness_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .sys_out_pins_i   (sys_out_pins_i),
    .sys_inout_to_i   (sys_inout_to_i),
    .sys_inout_en_i   (sys_inout_en_i),
    .rs485_i          (rs485_i),
    .cheri_err_i      (cheri_err_i),
    .sys_in_pins_o    (sys_in_pins_o),
    .sys_inout_from_o (sys_inout_from_o),
    .i2c_bus_o        (i2c_bus_o),
    .i2c_dev_i        (i2c_dev_i),
    .spi_o            (spi_o),
    .spi_cipo_i       (spi_cipo_i),
    .uart_tx_o        (uart_tx_o),
    .uart_rx_i        (uart_rx_i),
    .rs485_dev_rx_o   (rs485_dev_rx_o),
    .rs485_dev_tx_i   (rs485_dev_tx_i),
    .cheri_seen_o     (cheri_seen_o),
    .cheri_new_o      (cheri_new_o)
  );

  always #(Period / 2) clk_i = ~clk_i;

  // A released pin reads high.
  function automatic logic pin_level(logic lvl, logic en);
    return en ? lvl : 1'b1;
  endfunction

  // Random pins everywhere, then directed overrides per test group.
  task automatic fill_table();
    logic [31:0] r;
    int          c;
    for (int i = 0; i < NumRows; i++) begin
      r = $random(seed);
      stim_tbl[i].inout_to = r[15:0];
      stim_tbl[i].inout_en = r[31:16];
      r = $random(seed);
      stim_tbl[i].out_pins = r[7:0];
      stim_tbl[i].rs485    = r[10:8];
      stim_tbl[i].cheri    = r[19:11];
      stim_tbl[i].i2c_dev  = r[25:20];
      stim_tbl[i].cipo     = r[26];
      stim_tbl[i].uart_rx  = r[27];
      stim_tbl[i].dev_tx   = r[28];
      if (i < 12) begin
        stim_tbl[i].cheri = '0;
      end
      // Released pins with idle devices.
      if (i < 4) begin
        stim_tbl[i].inout_en = '0;
        stim_tbl[i].i2c_dev  = '1;
      end
      // All four controller and device combinations on every bus.
      if (i >= 4 && i < 8) begin
        c = i - 4;
        stim_tbl[i].inout_en = '1;
        for (int b = 0; b < NumI2cBuses; b++) begin
          stim_tbl[i].inout_to[SclPin[b]] = c[1];
          stim_tbl[i].inout_to[SdaPin[b]] = c[1];
          stim_tbl[i].i2c_dev[b]          = {c[0], c[0]};
        end
      end
      // RS-485 enable combinations.
      // Data is low so an enabled path differs from the idle level.
      if (i >= 8 && i < 12) begin
        c = i - 8;
        stim_tbl[i].rs485.tx        = 1'b0;
        stim_tbl[i].rs485.tx_enable = c[1];
        stim_tbl[i].rs485.rx_enable = c[0];
        stim_tbl[i].dev_tx          = 1'b0;
      end
    end
    // First hit, repeat, a new class beside an old one, then quiet.
    stim_tbl[8].cheri  = 9'h003;
    stim_tbl[9].cheri  = 9'h003;
    stim_tbl[10].cheri = 9'h011;
  endtask

  // Expected outputs from the pin rules.
  // Registered outputs follow the previous row, zero before the first.
  task automatic build_expected();
    stim_t      s;
    stim_t      p;
    expect_t    e;
    cheri_err_t mask;
    cheri_err_t mask_prev;
    logic       ctrl;
    mask      = '0;
    mask_prev = '0;
    for (int i = 0; i < NumRows; i++) begin
      s = stim_tbl[i];
      p = (i == 0) ? '0 : stim_tbl[i-1];
      e.inout_from = '1;
      for (int b = 0; b < NumI2cBuses; b++) begin
        ctrl                  = pin_level(s.inout_to[SclPin[b]], s.inout_en[SclPin[b]]);
        e.i2c_bus[b].scl      = ctrl & s.i2c_dev[b].scl;
        ctrl                  = pin_level(s.inout_to[SdaPin[b]], s.inout_en[SdaPin[b]]);
        e.i2c_bus[b].sda      = ctrl & s.i2c_dev[b].sda;
        e.inout_from[SclPin[b]] = e.i2c_bus[b].scl;
        e.inout_from[SdaPin[b]] = e.i2c_bus[b].sda;
      end
      e.inout_from[INOUT_PIN_PMOD1_3]   = s.cipo;
      e.inout_from[INOUT_PIN_PMOD0_10]  = p.inout_to[INOUT_PIN_PMOD0_8];
      e.inout_from[INOUT_PIN_PMOD0_1]   = p.out_pins[OUT_PIN_MB10];
      e.inout_from[INOUT_PIN_AH_TMPIO0] = p.inout_to[INOUT_PIN_AH_TMPIO1];
      e.inout_from[INOUT_PIN_AH_TMPIO9] = p.inout_to[INOUT_PIN_AH_TMPIO8];
      e.in_pins                  = '1;
      e.in_pins[IN_PIN_SER0_RX]  = s.uart_rx;
      e.in_pins[IN_PIN_RS485_RX] = s.rs485.rx_enable ? s.dev_tx : 1'b1;
      e.in_pins[IN_PIN_MB3]      = p.out_pins[OUT_PIN_MB4];
      e.in_pins[IN_PIN_MB8]      = p.out_pins[OUT_PIN_MB7];
      e.spi.cs   = pin_level(s.inout_to[INOUT_PIN_PMOD1_1], s.inout_en[INOUT_PIN_PMOD1_1]);
      e.spi.copi = pin_level(s.inout_to[INOUT_PIN_PMOD1_2], s.inout_en[INOUT_PIN_PMOD1_2]);
      e.spi.sck  = pin_level(s.inout_to[INOUT_PIN_PMOD1_4], s.inout_en[INOUT_PIN_PMOD1_4]);
      e.uart_tx  = s.out_pins[OUT_PIN_SER0_TX];
      e.rs485_rx = s.rs485.tx_enable ? s.rs485.tx : 1'b1;
      e.seen     = mask;
      e.pulse    = p.cheri & ~mask_prev;
      exp_tbl[i] = e;
      mask_prev  = mask;
      mask       = mask | s.cheri;
    end
  endtask

  task automatic drive_row(stim_t s);
    sys_out_pins_i = s.out_pins;
    sys_inout_to_i = s.inout_to;
    sys_inout_en_i = s.inout_en;
    rs485_i        = s.rs485;
    cheri_err_i    = s.cheri;
    i2c_dev_i      = s.i2c_dev;
    spi_cipo_i     = s.cipo;
    uart_rx_i      = s.uart_rx;
    rs485_dev_tx_i = s.dev_tx;
  endtask

  task automatic check_field(string name, logic [31:0] got, logic [31:0] exp, int row);
    checks++;
    assert (got == exp) else begin
      $display("Error at %0t ns: row %0d %s is %h, expected %h", $time, row, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_row(int i);
    expect_t e;
    e = exp_tbl[i];
    check_field("sys_in_pins", 32'(sys_in_pins_o), 32'(e.in_pins), i);
    check_field("sys_inout_from", 32'(sys_inout_from_o), 32'(e.inout_from), i);
    check_field("i2c_bus", 32'(i2c_bus_o), 32'(e.i2c_bus), i);
    check_field("spi", 32'(spi_o), 32'(e.spi), i);
    check_field("uart_tx", 32'(uart_tx_o), 32'(e.uart_tx), i);
    check_field("rs485_dev_rx", 32'(rs485_dev_rx_o), 32'(e.rs485_rx), i);
    check_field("cheri_seen", 32'(cheri_seen_o), 32'(e.seen), i);
    check_field("cheri_new", 32'(cheri_new_o), 32'(e.pulse), i);
  endtask

  // Ends a stuck run.
  initial begin
    #(Watchdog);
    $display("Watchdog expired before the row table was done");
    $display("Some tests failed");
    $finish;
  end

  initial begin
    rst_ni = 1'b0;
    drive_row('0);
    fill_table();
    build_expected();
    repeat (2) @(posedge clk_i);
    #(DriveDelay);
    rst_ni = 1'b1;
    for (int i = 0; i < NumRows; i++) begin
      @(posedge clk_i);
      #(DriveDelay);
      drive_row(stim_tbl[i]);
      #(Period / 2 - DriveDelay);
      check_row(i);
    end
    // Fill the mask and the loopback register, then reset mid-run.
    // Every registered output clears at once.
    @(posedge clk_i);
    #(DriveDelay);
    sys_out_pins_i = '1;
    sys_inout_to_i = '1;
    cheri_err_i    = '1;
    @(posedge clk_i);
    #(DriveDelay);
    rst_ni = 1'b0;
    #(DriveDelay);
    check_field("cheri_seen after reset", 32'(cheri_seen_o), 32'h0, NumRows);
    check_field("cheri_new after reset", 32'(cheri_new_o), 32'h0, NumRows);
    check_field("loopback after reset", 32'({
      sys_inout_from_o[INOUT_PIN_AH_TMPIO9],
      sys_inout_from_o[INOUT_PIN_AH_TMPIO0],
      sys_inout_from_o[INOUT_PIN_PMOD0_1],
      sys_in_pins_o[IN_PIN_MB8],
      sys_in_pins_o[IN_PIN_MB3],
      sys_inout_from_o[INOUT_PIN_PMOD0_10]
    }), 32'h0, NumRows);
    assert_fails = board_harness_inst.u_board_harness_assert.fail_cnt;
    $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
board_pkg.sv
pin_drive.sv
bus_resolve.sv
cheri_err_monitor.sv
board_harness.sv
board_harness_assert.sv
tb_board_harness.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the board harness testbench with Verilator.

LOG=sim.log

verilator --binary --timing --assert \
  --top-module tb_board_harness \
  -Mdir obj_dir -o sim_board_harness \
  -f vlog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_board_harness > "$LOG" 2>&1
RUN_STATUS=$?
cat "$LOG"
if [ $RUN_STATUS -ne 0 ]; then
  echo "Simulation exited with status $RUN_STATUS"
  exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
  exit 1
fi
if ! grep -q "All tests passed" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0
